// File: src/fir_pkg.sv
package fir_pkg;

	// line geometry
	localparam int LINE_LEN = 32;
	localparam int TAPS     = 7;

	// datapath widths
	localparam int SAMPLE_W = 8;
	localparam int COEF_W   = 9;
	localparam int PROD_W   = 17;
	localparam int SUM_W    = 20;
	localparam int RESULT_W = 16;

	// result keeps sum bits 18:3
	localparam int RESULT_SHIFT = 3;

	// sample counter must reach LINE_LEN
	localparam int CNT_W = 6;

	typedef logic [COEF_W-1:0] coef_set_t [TAPS];

	// entry 0 weights the oldest sample in the window
	localparam coef_set_t COEF_SMOOTH_B = '{
		9'd29, 9'd101, 9'd15, 9'd235, 9'd15, 9'd101, 9'd29
	};

	localparam coef_set_t COEF_SMOOTH_C = '{
		9'd4, 9'd42, 9'd163, 9'd255, 9'd163, 9'd42, 9'd4
	};

	// edge sets hold magnitudes only
	localparam coef_set_t COEF_EDGE_D = '{
		9'd12, 9'd77, 9'd148, 9'd0, 9'd148, 9'd77, 9'd12
	};

	localparam coef_set_t COEF_EDGE_E = '{
		9'd15, 9'd25, 9'd193, 9'd0, 9'd193, 9'd25, 9'd15
	};

	// coefficient set select
	typedef enum logic [1:0]
	{
		MODE_SMOOTH_B = 2'd0,
		MODE_SMOOTH_C = 2'd1,
		MODE_EDGE_D   = 2'd2,
		MODE_EDGE_E   = 2'd3
	} fir_mode_e;

	// per-line sequencing
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,
		ST_FILL = 2'd1,
		ST_RUN  = 2'd2
	} line_state_e;

endpackage

// File: src/fir_sample_counter.sv
`timescale 1ns/100ps

module fir_sample_counter
(
	input  logic clk,
	input  logic rst_n,
	input  logic cnt_clear,
	input  logic accept,
	output logic fill_last,
	output logic line_last
);

	logic [fir_pkg::CNT_W-1:0] cnt;

	// number of samples accepted so far in this line
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
		end
		else if (cnt_clear)
		begin
			cnt <= '0;
		end
		else if (accept)
		begin
			cnt <= cnt + 1'b1;
		end
	end

	// six samples held, so the current accept completes the window
	always_comb
	begin
		fill_last = (cnt == fir_pkg::CNT_W'(fir_pkg::TAPS - 1));
	end

	// current accept is the last sample of the line
	always_comb
	begin
		line_last = (cnt == fir_pkg::CNT_W'(fir_pkg::LINE_LEN - 1));
	end

endmodule

// File: src/fir_line_ctrl.sv
`timescale 1ns/100ps

module fir_line_ctrl
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  fir_pkg::fir_mode_e  mode,
	input  logic                sample_strobe,
	input  logic                fill_last,
	input  logic                line_last,
	output logic                accept,
	output logic                cnt_clear,
	output logic                win_valid,
	output fir_pkg::fir_mode_e  mode_q,
	output logic                line_done,
	output logic                busy
);

	fir_pkg::line_state_e state;
	fir_pkg::line_state_e state_nxt;

	// strobes outside a line are dropped
	always_comb
	begin
		accept = sample_strobe && (state != fir_pkg::ST_IDLE);
	end

	// start while busy is ignored
	always_comb
	begin
		cnt_clear = start && (state == fir_pkg::ST_IDLE);
	end

	// window is complete on the seventh accept and stays so for the rest of the line
	always_comb
	begin
		win_valid = accept && ((state == fir_pkg::ST_RUN) || fill_last);
	end

	always_comb
	begin
		busy = (state != fir_pkg::ST_IDLE);
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			fir_pkg::ST_IDLE:
			begin
				if (start)
				begin
					state_nxt = fir_pkg::ST_FILL;
				end
			end
			fir_pkg::ST_FILL:
			begin
				if (accept && fill_last)
				begin
					state_nxt = fir_pkg::ST_RUN;
				end
			end
			fir_pkg::ST_RUN:
			begin
				if (accept && line_last)
				begin
					state_nxt = fir_pkg::ST_IDLE;
				end
			end
			default:
			begin
				state_nxt = fir_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= fir_pkg::ST_IDLE;
			mode_q    <= fir_pkg::MODE_SMOOTH_B;
			line_done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// mode held for the whole line
			if (cnt_clear)
			begin
				mode_q <= mode;
			end
			line_done <= accept && line_last && (state == fir_pkg::ST_RUN);
		end
	end

endmodule

// File: src/fir_window.sv
`timescale 1ns/100ps

module fir_window
(
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          accept,
	input  logic [fir_pkg::SAMPLE_W-1:0]                  sample,
	output logic [fir_pkg::TAPS*fir_pkg::SAMPLE_W-1:0]    window
);

	localparam int KEEP_W = (fir_pkg::TAPS - 1) * fir_pkg::SAMPLE_W;

	// newest sample enters the low byte, oldest drops off the top
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			window <= '0;
		end
		else if (accept)
		begin
			window <= {window[KEEP_W-1:0], sample};
		end
	end

endmodule

// File: src/fir_compute.sv
`timescale 1ns/100ps

module fir_compute
(
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic [fir_pkg::TAPS*fir_pkg::SAMPLE_W-1:0]    window,
	input  logic                                          win_valid,
	input  fir_pkg::fir_mode_e                            mode_q,
	output logic [fir_pkg::RESULT_W-1:0]                  result,
	output logic                                          result_valid
);

	fir_pkg::coef_set_t coef;

	logic [fir_pkg::SAMPLE_W-1:0] tap [fir_pkg::TAPS];
	logic [fir_pkg::PROD_W-1:0]   prod_q [fir_pkg::TAPS];
	logic [fir_pkg::SUM_W-1:0]    sum_nxt;
	logic [fir_pkg::SUM_W-1:0]    sum_q;

	// win_valid delayed past the edge that updates the window
	logic       win_valid_q;
	logic [2:0] valid_sr;

	// coefficient set of the current line
	always_comb
	begin
		case (mode_q)
			fir_pkg::MODE_SMOOTH_B: coef = fir_pkg::COEF_SMOOTH_B;
			fir_pkg::MODE_SMOOTH_C: coef = fir_pkg::COEF_SMOOTH_C;
			fir_pkg::MODE_EDGE_D:   coef = fir_pkg::COEF_EDGE_D;
			default:                coef = fir_pkg::COEF_EDGE_E;
		endcase
	end

	// tap 0 is the oldest sample in the top byte
	always_comb
	begin
		for (int i = 0; i < fir_pkg::TAPS; i++)
		begin
			tap[i] = window[(fir_pkg::TAPS-1-i)*fir_pkg::SAMPLE_W +: fir_pkg::SAMPLE_W];
		end
	end

	// first stage registers the products
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < fir_pkg::TAPS; i++)
		begin
			prod_q[i] <= fir_pkg::PROD_W'(tap[i] * coef[i]);
		end
	end

	// adder over the unsigned products
	always_comb
	begin
		sum_nxt = '0;
		for (int i = 0; i < fir_pkg::TAPS; i++)
		begin
			sum_nxt = sum_nxt + fir_pkg::SUM_W'(prod_q[i]);
		end
	end

	// second stage registers the sum
	always_ff @(posedge clk)
	begin
		sum_q <= sum_nxt;
	end

	// third stage registers the scaled result
	always_ff @(posedge clk)
	begin
		result <= fir_pkg::RESULT_W'(sum_q >> fir_pkg::RESULT_SHIFT);
	end

	// valid follows the data through the three stages
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			win_valid_q <= 1'b0;
			valid_sr    <= '0;
		end
		else
		begin
			win_valid_q <= win_valid;
			valid_sr    <= {valid_sr[1:0], win_valid_q};
		end
	end

	always_comb
	begin
		result_valid = valid_sr[2];
	end

endmodule

// File: src/fir_bank_top.sv
`timescale 1ns/100ps

module fir_bank_top
(
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start,
	input  fir_pkg::fir_mode_e              mode,
	input  logic                            sample_strobe,
	input  logic [fir_pkg::SAMPLE_W-1:0]    sample,
	output logic [fir_pkg::RESULT_W-1:0]    result,
	output logic                            result_valid,
	output logic                            line_done,
	output logic                            busy
);

	logic                                          accept;
	logic                                          cnt_clear;
	logic                                          win_valid;
	logic                                          fill_last;
	logic                                          line_last;
	fir_pkg::fir_mode_e                            mode_q;
	logic [fir_pkg::TAPS*fir_pkg::SAMPLE_W-1:0]    window;

	fir_line_ctrl i_fir_line_ctrl
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.mode          (mode),
		.sample_strobe (sample_strobe),
		.fill_last     (fill_last),
		.line_last     (line_last),
		.accept        (accept),
		.cnt_clear     (cnt_clear),
		.win_valid     (win_valid),
		.mode_q        (mode_q),
		.line_done     (line_done),
		.busy          (busy)
	);

	fir_sample_counter i_fir_sample_counter
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cnt_clear (cnt_clear),
		.accept    (accept),
		.fill_last (fill_last),
		.line_last (line_last)
	);

	fir_window i_fir_window
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.accept (accept),
		.sample (sample),
		.window (window)
	);

	fir_compute i_fir_compute
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.window       (window),
		.win_valid    (win_valid),
		.mode_q       (mode_q),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// File: verif/fir_bank_chk.sv
`timescale 1ns/100ps

module fir_bank_chk
(
	input logic       clk,
	input logic       rst_n,
	input logic       win_valid,
	input logic       result_valid,
	input logic       line_done,
	input logic       busy,
	input logic [1:0] state
);

	// outputs cleared by a reset edge
	reset_quiet: assert property (@(posedge clk) !rst_n |=> (!result_valid && !line_done && !busy))
		else $error("output high after a reset edge");

	// single-cycle pulse with busy already low
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		line_done |-> !busy ##1 !line_done)
		else $error("line_done not a single pulse with busy low");

	// fixed pipeline latency
	result_latency: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> $past(win_valid, 4))
		else $error("result_valid without win_valid four cycles earlier");

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {fir_pkg::ST_IDLE, fir_pkg::ST_FILL, fir_pkg::ST_RUN})
		else $error("line state outside its encoding");

endmodule

bind fir_bank_top fir_bank_chk i_fir_bank_chk
(
	.clk          (clk),
	.rst_n        (rst_n),
	.win_valid    (win_valid),
	.result_valid (result_valid),
	.line_done    (line_done),
	.busy         (busy),
	.state        (i_fir_line_ctrl.state)
);

// File: verif/fir_bank_tb.sv
`timescale 1ns/100ps

module fir_bank_tb;

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic                         start;
	fir_pkg::fir_mode_e           mode;
	logic                         sample_strobe;
	logic [fir_pkg::SAMPLE_W-1:0] sample;
	logic [fir_pkg::RESULT_W-1:0] result;
	logic                         result_valid;
	logic                         line_done;
	logic                         busy;

	integer seed = 32'h26ab;

	// model of the line and its expected results
	int                 hist [fir_pkg::TAPS];
	int                 model_cnt = 0;
	bit                 model_busy = 1'b0;
	bit                 done_due = 1'b0;
	fir_pkg::fir_mode_e model_mode = fir_pkg::MODE_SMOOTH_B;
	int                 exp_val [$];
	int                 exp_cyc [$];
	int                 cyc = 0;
	int                 result_count = 0;
	int                 done_count = 0;
	int                 lines_run = 0;

	fir_bank_top i_fir_bank_top
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (start),
		.mode          (mode),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.result        (result),
		.result_valid  (result_valid),
		.line_done     (line_done),
		.busy          (busy)
	);

	always #4 clk = ~clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// hist[0] holds the oldest sample and takes entry 0
	function automatic int expected_result(input fir_pkg::fir_mode_e m);
		fir_pkg::coef_set_t w;
		int                 acc;
		case (m)
			fir_pkg::MODE_SMOOTH_B: w = fir_pkg::COEF_SMOOTH_B;
			fir_pkg::MODE_SMOOTH_C: w = fir_pkg::COEF_SMOOTH_C;
			fir_pkg::MODE_EDGE_D:   w = fir_pkg::COEF_EDGE_D;
			default:                w = fir_pkg::COEF_EDGE_E;
		endcase
		acc = 0;
		for (int i = 0; i < fir_pkg::TAPS; i++)
		begin
			acc = acc + hist[i] * int'(w[i]);
		end
		return (acc >> 3) & 32'hffff;
	endfunction

	// inputs seen here are the values the DUT samples on this edge
	always @(posedge clk)
	begin : monitor
		bit expect_now;
		if (rst_n)
		begin
			cyc = cyc + 1;
			assert (busy == model_busy)
				else stop_run($sformatf("Fail %0t: busy %0b, expected %0b", $time, busy, model_busy));
			assert (line_done == done_due)
				else stop_run($sformatf("Fail %0t: line_done %0b, expected %0b", $time,
					line_done, done_due));
			if (line_done)
			begin
				done_count++;
			end
			expect_now = (exp_cyc.size() > 0) && (exp_cyc[0] == cyc);
			assert (result_valid == expect_now)
				else stop_run($sformatf("Fail %0t: result_valid %0b, expected %0b", $time,
					result_valid, expect_now));
			if (result_valid)
			begin
				assert (int'(result) == exp_val[0])
					else stop_run($sformatf("Fail %0t: result %0d, expected %0d", $time,
						result, exp_val[0]));
				void'(exp_val.pop_front());
				void'(exp_cyc.pop_front());
				result_count++;
			end
			done_due = 1'b0;
			if (model_busy && sample_strobe)
			begin
				for (int i = 0; i < fir_pkg::TAPS - 1; i++)
				begin
					hist[i] = hist[i+1];
				end
				hist[fir_pkg::TAPS-1] = int'(sample);
				model_cnt++;
				// result due on the fourth edge after this one
				if (model_cnt >= fir_pkg::TAPS)
				begin
					exp_val.push_back(expected_result(model_mode));
					exp_cyc.push_back(cyc + 4);
				end
				if (model_cnt == fir_pkg::LINE_LEN)
				begin
					model_busy = 1'b0;
					done_due   = 1'b1;
				end
			end
			else if (!model_busy && start)
			begin
				model_busy = 1'b1;
				model_cnt  = 0;
				model_mode = mode;
			end
		end
	end

	// runs one line while mode and stray starts keep changing
	task automatic run_line(input fir_pkg::fir_mode_e m, input bit use_gaps);
		int gap;
		int t;
		start         <= 1'b1;
		mode          <= m;
		sample_strobe <= 1'b0;
		@(posedge clk);
		start <= 1'b0;
		for (int n = 0; n < fir_pkg::LINE_LEN; n++)
		begin
			gap = use_gaps ? ($random(seed) & 3) : 0;
			repeat (gap)
			begin
				sample_strobe <= 1'b0;
				start         <= (($random(seed) & 7) == 0);
				@(posedge clk);
			end
			sample_strobe <= 1'b1;
			start         <= 1'b0;
			sample        <= 8'($random(seed));
			mode          <= fir_pkg::fir_mode_e'(2'($random(seed)));
			@(posedge clk);
		end
		sample_strobe <= 1'b0;
		for (t = 0; busy; t++)
		begin
			assert (t < 20) else stop_run("timeout: busy did not fall at the end of a line");
			@(posedge clk);
		end
		lines_run++;
	endtask

	// strobes with no line running
	task automatic idle_strobes(input int n);
		repeat (n)
		begin
			sample_strobe <= 1'b1;
			sample        <= 8'($random(seed));
			@(posedge clk);
		end
		sample_strobe <= 1'b0;
	endtask

	initial
	begin
		fir_pkg::fir_mode_e m;
		int                 t;
		rst_n         = 1'b0;
		start         = 1'b0;
		mode          = fir_pkg::MODE_SMOOTH_B;
		sample_strobe = 1'b0;
		sample        = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		// more idle strobes than the window-full count
		idle_strobes(fir_pkg::TAPS + 3);
		for (int l = 0; l < 12; l++)
		begin
			// first four lines cover every mode
			m = (l < 4) ? fir_pkg::fir_mode_e'(2'(l)) : fir_pkg::fir_mode_e'(2'($random(seed)));
			run_line(m, (l % 3) != 0);
			idle_strobes(3);
		end
		for (t = 0; exp_val.size() > 0; t++)
		begin
			assert (t < 20) else stop_run("timeout: expected results never arrived");
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		assert (result_count == lines_run * (fir_pkg::LINE_LEN - fir_pkg::TAPS + 1))
			else stop_run($sformatf("Fail %0t: %0d results, expected %0d", $time, result_count,
				lines_run * (fir_pkg::LINE_LEN - fir_pkg::TAPS + 1)));
		assert (done_count == lines_run)
			else stop_run($sformatf("Fail %0t: %0d line_done pulses, expected %0d", $time,
				done_count, lines_run));
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: fir_bank.f
src/fir_pkg.sv
src/fir_sample_counter.sv
src/fir_line_ctrl.sv
src/fir_window.sv
src/fir_compute.sv
src/fir_bank_top.sv
verif/fir_bank_chk.sv
verif/fir_bank_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

# build and run the fir_bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -f fir_bank.f --top-module fir_bank_tb \
	--Mdir obj_dir -o fir_bank_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/fir_bank_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation PASSED"
exit 0
